// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := mipsPipelineTb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mipsModel.svh ====
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

typedef logic [31:0] wordQ[$];

// instruction encodings of the supported subset
localparam logic [5:0] opRType = 6'd0;
localparam logic [5:0] opJump  = 6'd2;
localparam logic [5:0] opBeq   = 6'd4;
localparam logic [5:0] opAddi  = 6'd8;
localparam logic [5:0] opLw    = 6'd35;
localparam logic [5:0] opSw    = 6'd43;
localparam logic [5:0] opHalt  = 6'd63;

localparam logic [5:0] fnAdd = 6'h20;
localparam logic [5:0] fnSub = 6'h22;
localparam logic [5:0] fnAnd = 6'h24;
localparam logic [5:0] fnOr  = 6'h25;
localparam logic [5:0] fnSlt = 6'h2a;

// sequential interpreter, one instruction per step, stops at halt
function automatic void runModel(input wordQ code, output wordQ addrs, output wordQ datas);
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] value;
    logic [4:0]  dest;
    logic        wr;
    logic        done;
    int          idx;
    int          steps;
    addrs = {};
    datas = {};
    foreach (regs[r]) begin
        regs[r] = '0;
    end
    foreach (mem[m]) begin
        mem[m] = '0;
    end
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 10000) begin
        idx = int'(pc >> 2);
        // running off the end of the program counts as a halt
        ins = (idx < code.size()) ? code[idx] : {opHalt, 26'd0};
        pcNext = pc + 32'd4;
        a = regs[ins[25:21]];
        b = regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        wr = 1'b0;
        dest = ins[20:16];
        value = addr;
        case (ins[31:26])
            opRType: begin
                wr = 1'b1;
                dest = ins[15:11];
                case (ins[5:0])
                    fnAdd:   value = a + b;
                    fnSub:   value = a - b;
                    fnAnd:   value = a & b;
                    fnOr:    value = a | b;
                    fnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            opAddi: wr = 1'b1;
            opLw: begin
                wr = 1'b1;
                value = mem[addr[9:2]];
            end
            opSw: begin
                mem[addr[9:2]] = b;
                addrs.push_back(addr);
                datas.push_back(b);
            end
            opBeq: begin
                if (a == b) begin
                    pcNext = pcNext + (imm << 2);
                end
            end
            opJump:  pcNext = {pcNext[31:28], ins[25:0], 2'b00};
            opHalt:  done = 1'b1;
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            regs[dest] = value;
        end
        pc = pcNext;
        steps++;
    end
endfunction

`endif

// ==== bench/mipsPipelineTb.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsPipelineTb;
    import mipsPkg::*;

    `include "mipsModel.svh"

    logic                  clk;
    logic                  reset;
    logic                  progWrite;
    logic [`MIPS_WORD-1:0] progAddr;
    logic [`MIPS_WORD-1:0] progData;
    storeEventT            storeEvent;
    logic                  fin;

    wordQ prog;
    wordQ expAddr;
    wordQ expData;
    int   seen;
    int   errors;
    int   passCount;
    int   failCount;

    mipsPipeline dut (
        .clk        (clk),
        .reset      (reset),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeEvent (storeEvent),
        .fin        (fin)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] rTypeWord(input logic [5:0] funct, input int rd,
                                              input int rs, input int rt);
        return {opRType, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] immWord(input logic [5:0] op, input int rt,
                                            input int rs, input logic [31:0] imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // target is a word index and the upper PC bits stay zero
    function automatic logic [31:0] jumpWord(input int target);
        return {opJump, target[25:0]};
    endfunction

    function automatic logic [31:0] haltWord();
        return {opHalt, 26'd0};
    endfunction

    function automatic logic [5:0] aluFunct(input int k);
        case (k)
            0:       return fnAdd;
            1:       return fnSub;
            2:       return fnAnd;
            3:       return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    // every store leaving the memory stage is checked in order
    always @(posedge clk) begin
        if (!reset && storeEvent.valid) begin
            if (seen >= expAddr.size()) begin
                $display("unexpected store to %h with data %h after the expected list",
                         storeEvent.addr, storeEvent.data);
                errors++;
            end else begin
                if (storeEvent.addr !== expAddr[seen]) begin
                    $display("CHECK FAILED storeEvent.addr got %h expected %h",
                             storeEvent.addr, expAddr[seen]);
                    errors++;
                end
                if (storeEvent.data !== expData[seen]) begin
                    $display("CHECK FAILED storeEvent.data got %h expected %h",
                             storeEvent.data, expData[seen]);
                    errors++;
                end
            end
            seen++;
        end
    end

    // the program goes in while reset is high and two more reset cycles follow
    task automatic loadProgram();
        reset = 1'b1;
        foreach (prog[i]) begin
            progWrite = 1'b1;
            progAddr = i * 4;
            progData = prog[i];
            @(negedge clk);
        end
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic runTest(input string name);
        int errorsBefore;
        int cycles;
        int seenAtFin;
        errorsBefore = errors;
        runModel(prog, expAddr, expData);
        seen = 0;
        loadProgram();
        cycles = 0;
        while (!fin && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!fin) begin
            $display("fin did not rise within 2000 cycles in %s", name);
            errors++;
        end else begin
            seenAtFin = seen;
            for (int c = 0; c < 20; c++) begin
                @(negedge clk);
                if (!fin) begin
                    $display("fin dropped %0d cycles after it rose", c + 1);
                    errors++;
                end
            end
            if (seen != seenAtFin) begin
                $display("%0d stores appeared after the halt", seen - seenAtFin);
                errors++;
            end
        end
        if (seen != expAddr.size()) begin
            $display("store count is %0d but the model made %0d", seen, expAddr.size());
            errors++;
        end
        if (errors == errorsBefore) begin
            $display("test %s: passed, %0d stores", name, seen);
            passCount++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errorsBefore);
            failCount++;
        end
    endtask

    task automatic dependencyChain();
        prog = {};
        prog.push_back(immWord(opAddi, 1, 0, $urandom));
        // each step uses the previous result from EX/MEM and an older one from MEM/WB
        prog.push_back(immWord(opAddi, 2, 1, $urandom));
        prog.push_back(rTypeWord(fnAdd, 3, 2, 1));
        prog.push_back(rTypeWord(fnSub, 4, 3, 2));
        prog.push_back(rTypeWord(fnAnd, 5, 4, 3));
        prog.push_back(rTypeWord(fnOr, 6, 5, 4));
        prog.push_back(rTypeWord(fnSlt, 7, 6, 3));
        prog.push_back(immWord(opAddi, 8, 7, $urandom));
        for (int r = 3; r <= 8; r++) begin
            prog.push_back(immWord(opSw, r, 0, (r - 3) * 4));
        end
        prog.push_back(haltWord());
    endtask

    task automatic loadUse();
        prog = {};
        prog.push_back(immWord(opAddi, 1, 0, $urandom));
        prog.push_back(immWord(opSw, 1, 0, 0));
        prog.push_back(immWord(opLw, 2, 0, 0));
        prog.push_back(rTypeWord(fnAdd, 3, 2, 1));
        prog.push_back(immWord(opSw, 3, 0, 4));
        prog.push_back(haltWord());
    endtask

    task automatic storeDependency();
        prog = {};
        prog.push_back(immWord(opAddi, 1, 0, $urandom));
        prog.push_back(immWord(opSw, 1, 0, 8));
        prog.push_back(immWord(opAddi, 2, 1, $urandom));
        prog.push_back(immWord(opSw, 2, 0, 12));
        prog.push_back(rTypeWord(fnOr, 3, 2, 1));
        prog.push_back(immWord(opSw, 3, 0, 16));
        prog.push_back(haltWord());
    endtask

    task automatic controlFlow();
        prog = {};
        prog.push_back(immWord(opAddi, 1, 0, 5));
        prog.push_back(immWord(opAddi, 2, 0, 5));
        // taken branch that lands on word 6
        prog.push_back(immWord(opBeq, 2, 1, 3));
        prog.push_back(immWord(opSw, 1, 0, 0));
        prog.push_back(immWord(opSw, 2, 0, 4));
        prog.push_back(immWord(opSw, 1, 0, 8));
        // not taken since r1 is nonzero
        prog.push_back(immWord(opBeq, 0, 1, 1));
        prog.push_back(immWord(opSw, 1, 0, 12));
        prog.push_back(jumpWord(12));
        prog.push_back(immWord(opSw, 1, 0, 16));
        prog.push_back(immWord(opSw, 1, 0, 20));
        prog.push_back(immWord(opSw, 1, 0, 24));
        prog.push_back(immWord(opSw, 2, 0, 28));
        prog.push_back(haltWord());
    endtask

    task automatic haltStop();
        prog = {};
        prog.push_back(immWord(opAddi, 1, 0, $urandom));
        prog.push_back(immWord(opSw, 1, 0, 0));
        prog.push_back(haltWord());
        prog.push_back(immWord(opSw, 1, 0, 4));
        prog.push_back(immWord(opSw, 1, 0, 8));
    endtask

    task automatic randomProgram();
        int kind;
        int rd;
        int rs;
        int rt;
        int target;
        prog = {};
        // fill the four data words first so every later load reads a stored word
        for (int i = 0; i < 4; i++) begin
            prog.push_back(immWord(opAddi, i + 1, 0, $urandom));
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(immWord(opSw, i + 1, 0, i * 4));
        end
        while (prog.size() < 39) begin
            kind = $urandom_range(0, 9);
            rd = $urandom_range(0, 7);
            rs = $urandom_range(0, 7);
            rt = $urandom_range(0, 7);
            // forward targets only and never past the halt
            target = prog.size() + 1 + $urandom_range(0, 3);
            if (target > 39) begin
                target = 39;
            end
            case (kind)
                0, 1, 2: prog.push_back(rTypeWord(aluFunct($urandom_range(0, 4)), rd, rs, rt));
                3, 4:    prog.push_back(immWord(opAddi, rd, rs, $urandom));
                5:       prog.push_back(immWord(opLw, rd, 0, $urandom_range(0, 3) * 4));
                7:       prog.push_back(immWord(opBeq, rt, rs, target - (prog.size() + 1)));
                8:       prog.push_back(jumpWord(target));
                default: prog.push_back(immWord(opSw, rt, 0, $urandom_range(0, 3) * 4));
            endcase
        end
        prog.push_back(haltWord());
    endtask

    initial begin
        void'($urandom(16));
        clk = 1'b0;
        reset = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        seen = 0;
        errors = 0;
        passCount = 0;
        failCount = 0;
        @(negedge clk);

        dependencyChain();
        runTest("dependency chain");
        loadUse();
        runTest("load use");
        storeDependency();
        runTest("store data dependency");
        controlFlow();
        runTest("control flow");
        haltStop();
        runTest("halt");
        randomProgram();
        runTest("random program");

        $display("%0d tests passed, %0d tests failed, %0d errors", passCount, failCount, errors);
        if (failCount == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
+incdir+bench
logic/mipsPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/mipsPipeline.sv
bench/mipsPipelineTb.sv

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  mipsPkg::ifIdT         ifId,
    input  mipsPkg::memWbT        memWb,
    input  logic [`MIPS_WORD-1:0] wbData,
    output mipsPkg::idExT         idEx
);
    import mipsPkg::*;

    localparam int numRegs = 1 << `MIPS_REG_ADDR;

    logic [`MIPS_WORD-1:0]     regs [numRegs];
    logic [`MIPS_REG_ADDR-1:0] rs;
    logic [`MIPS_REG_ADDR-1:0] rt;
    logic [`MIPS_REG_ADDR-1:0] rd;
    logic [`MIPS_WORD-1:0]     rsVal;
    logic [`MIPS_WORD-1:0]     rtVal;
    logic [`MIPS_WORD-1:0]     imm;
    logic [`MIPS_WORD-1:0]     jumpTarget;
    ctrlT                      ctrl;
    idExT                      idExNext;

    assign rs = ifId.instr[25:21];
    assign rt = ifId.instr[20:16];
    assign rd = ifId.instr[15:11];

    // main control
    always_comb begin
        ctrl = '0;
        if (ifId.valid) begin
            case (ifId.instr[31:26])
                rType: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = 1'b1;
                    ctrl.useFunct = 1'b1;
                end
                addi: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                lw: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                sw: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                end
                beq: begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = aluSub;
                end
                j:       ctrl.jump = 1'b1;
                halt:    ctrl.halt = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    // register 0 is hardwired, and the writeback value bypasses the array
    assign rsVal = (rs == '0) ? '0 :
                   (memWb.regWrite && memWb.dest == rs) ? wbData : regs[rs];
    assign rtVal = (rt == '0) ? '0 :
                   (memWb.regWrite && memWb.dest == rt) ? wbData : regs[rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (memWb.regWrite && memWb.dest != '0) begin
            regs[memWb.dest] <= wbData;
        end
    end

    assign imm = {{(`MIPS_WORD-16){ifId.instr[15]}}, ifId.instr[15:0]};

    // a halt carries its own address so memory can park fetch on it
    assign jumpTarget = ctrl.halt ? ifId.pcNext - `MIPS_WORD'(4) :
                        {ifId.pcNext[31:28], ifId.instr[25:0], 2'b00};

    assign idExNext = '{
        ctrl:         ctrl,
        rsVal:        rsVal,
        rtVal:        rtVal,
        imm:          imm,
        rs:           rs,
        rt:           rt,
        rd:           rd,
        funct:        ifId.instr[5:0],
        branchTarget: ifId.pcNext + (imm << 2),
        jumpTarget:   jumpTarget
    };

    // a bubble is an all-zero entry
    always_ff @(posedge clk) begin
        if (reset || stall || flush) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module executeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  mipsPkg::idExT         idEx,
    input  mipsPkg::fwdSelT       fwdA,
    input  mipsPkg::fwdSelT       fwdB,
    input  logic [`MIPS_WORD-1:0] wbData,
    output mipsPkg::exMemT        exMem
);
    import mipsPkg::*;

    // R-type function codes
    localparam logic [5:0] functAdd = 6'h20;
    localparam logic [5:0] functSub = 6'h22;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr  = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    logic [`MIPS_WORD-1:0] opA;
    logic [`MIPS_WORD-1:0] rtFwd;
    logic [`MIPS_WORD-1:0] opB;
    logic [`MIPS_WORD-1:0] result;
    aluOpT                 aluOp;
    logic                  functOk;

    function automatic logic [`MIPS_WORD-1:0] pickOperand(
        input fwdSelT                sel,
        input logic [`MIPS_WORD-1:0] regVal,
        input logic [`MIPS_WORD-1:0] exVal,
        input logic [`MIPS_WORD-1:0] wbVal
    );
        case (sel)
            fwdExMem: return exVal;
            fwdMemWb: return wbVal;
            default:  return regVal;
        endcase
    endfunction

    assign opA   = pickOperand(fwdA, idEx.rsVal, exMem.aluResult, wbData);
    assign rtFwd = pickOperand(fwdB, idEx.rtVal, exMem.aluResult, wbData);
    assign opB   = idEx.ctrl.aluSrc ? idEx.imm : rtFwd;

    // ALU control
    always_comb begin
        aluOp   = idEx.ctrl.aluOp;
        functOk = 1'b1;
        if (idEx.ctrl.useFunct) begin
            case (idEx.funct)
                functAdd: aluOp = aluAdd;
                functSub: aluOp = aluSub;
                functAnd: aluOp = aluAnd;
                functOr:  aluOp = aluOr;
                functSlt: aluOp = aluSlt;
                default:  functOk = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = `MIPS_WORD'($signed(opA) < $signed(opB));
            default: result = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exMem <= '0;
        end else begin
            exMem <= '{
                regWrite:     idEx.ctrl.regWrite,
                memRead:      idEx.ctrl.memRead,
                memWrite:     idEx.ctrl.memWrite,
                memToReg:     idEx.ctrl.memToReg,
                branch:       idEx.ctrl.branch,
                jump:         idEx.ctrl.jump,
                halt:         idEx.ctrl.halt,
                aluResult:    result,
                zero:         result == '0,
                // store data sees the same forwarding as operand B
                storeData:    rtFwd,
                dest:         idEx.ctrl.regDst ? idEx.rd : idEx.rt,
                branchTarget: idEx.branchTarget,
                jumpTarget:   idEx.jumpTarget
            };
        end
    end

    assert property (@(posedge clk) disable iff (reset) idEx.ctrl.useFunct |-> functOk)
        else $error("R-type with unsupported funct %h", idEx.funct);

endmodule

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetchStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  redirect,
    input  logic [`MIPS_WORD-1:0] redirectPc,
    input  logic                  progWrite,
    input  logic [`MIPS_WORD-1:0] progAddr,
    input  logic [`MIPS_WORD-1:0] progData,
    output mipsPkg::ifIdT         ifId
);
    import mipsPkg::*;

    localparam int idxBits = $clog2(`MIPS_IMEM_DEPTH);

    logic [`MIPS_WORD-1:0] imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_WORD-1:0] pc;
    logic [`MIPS_WORD-1:0] pcPlus4;
    logic [`MIPS_WORD-1:0] instr;
    logic                  frozen;

    assign instr   = imem[pc[idxBits+1:2]];
    assign pcPlus4 = pc + `MIPS_WORD'(4);
    // the PC parks on a halt and waits for it to drain
    assign frozen  = instr[31:26] == halt;

    // program loader, only live while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && progWrite) begin
            imem[progAddr[idxBits+1:2]] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall && !frozen) begin
            pc <= pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId <= '{valid: 1'b1, instr: instr, pcNext: pcPlus4};
        end
    end

    assert property (@(posedge clk) progWrite |-> reset)
        else $error("program write while the core is running");

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module hazardUnit (
    input  mipsPkg::ifIdT   ifId,
    input  mipsPkg::idExT   idEx,
    input  mipsPkg::exMemT  exMem,
    input  mipsPkg::memWbT  memWb,
    input  logic            redirect,
    output logic            stall,
    output logic            flush,
    output mipsPkg::fwdSelT fwdA,
    output mipsPkg::fwdSelT fwdB
);
    import mipsPkg::*;

    logic [`MIPS_REG_ADDR-1:0] idRs;
    logic [`MIPS_REG_ADDR-1:0] idRt;
    logic                      loadUse;

    // the younger result wins when both stages write the same register
    function automatic fwdSelT pickSource(
        input logic [`MIPS_REG_ADDR-1:0] src,
        input exMemT                     em,
        input memWbT                     mw
    );
        if (em.regWrite && em.dest != '0 && em.dest == src) begin
            return fwdExMem;
        end
        if (mw.regWrite && mw.dest != '0 && mw.dest == src) begin
            return fwdMemWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

    assign idRs = ifId.instr[25:21];
    assign idRt = ifId.instr[20:16];

    // load in execute feeding the instruction in decode
    assign loadUse = idEx.ctrl.memRead && ifId.valid && idEx.rt != '0 &&
                     (idEx.rt == idRs || idEx.rt == idRt);

    assign flush = redirect;
    assign stall = loadUse && !redirect;

endmodule

// ==== logic/memoryStage.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module memoryStage (
    input  logic                  clk,
    input  logic                  reset,
    input  mipsPkg::exMemT        exMem,
    output mipsPkg::memWbT        memWb,
    output logic [`MIPS_WORD-1:0] wbData,
    output logic                  redirect,
    output logic [`MIPS_WORD-1:0] redirectPc,
    output mipsPkg::storeEventT   storeEvent,
    output logic                  fin
);
    import mipsPkg::*;

    localparam int idxBits = $clog2(`MIPS_DMEM_DEPTH);

    logic [`MIPS_WORD-1:0] dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_WORD-1:0] loadData;
    logic                  finSeen;

    assign loadData = dmem[exMem.aluResult[idxBits+1:2]];

    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dmem[exMem.aluResult[idxBits+1:2]] <= exMem.storeData;
        end
    end

    assign storeEvent = '{valid: exMem.memWrite, addr: exMem.aluResult, data: exMem.storeData};

    // beq compares through subtraction, so zero means equal
    assign redirect   = exMem.jump || exMem.halt || (exMem.branch && exMem.zero);
    assign redirectPc = exMem.branch ? exMem.branchTarget : exMem.jumpTarget;

    always_ff @(posedge clk) begin
        if (reset) begin
            memWb <= '0;
        end else begin
            memWb <= '{
                regWrite:  exMem.regWrite,
                memToReg:  exMem.memToReg,
                halt:      exMem.halt,
                aluResult: exMem.aluResult,
                loadData:  loadData,
                dest:      exMem.dest
            };
        end
    end

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    // fin holds from the first halt in writeback until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            finSeen <= 1'b0;
        end else if (memWb.halt) begin
            finSeen <= 1'b1;
        end
    end

    assign fin = finSeen || memWb.halt;

    // the flush that goes with a redirect leaves a bubble in memory
    assert property (@(posedge clk) disable iff (reset)
        redirect |=> !exMem.regWrite && !exMem.memWrite && !redirect)
        else $error("instruction survived a redirect flush");

endmodule

// ==== logic/mipsPipeline.sv ====
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsPipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  progWrite,
    input  logic [`MIPS_WORD-1:0] progAddr,
    input  logic [`MIPS_WORD-1:0] progData,
    output mipsPkg::storeEventT   storeEvent,
    output logic                  fin
);
    import mipsPkg::*;

    ifIdT                  ifId;
    idExT                  idEx;
    exMemT                 exMem;
    memWbT                 memWb;
    logic [`MIPS_WORD-1:0] wbData;
    logic [`MIPS_WORD-1:0] redirectPc;
    logic                  redirect;
    logic                  stall;
    logic                  flush;
    fwdSelT                fwdA;
    fwdSelT                fwdB;

    fetchStage uFetch (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .ifId       (ifId)
    );

    decodeStage uDecode (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .flush  (flush),
        .ifId   (ifId),
        .memWb  (memWb),
        .wbData (wbData),
        .idEx   (idEx)
    );

    executeStage uExecute (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .idEx   (idEx),
        .fwdA   (fwdA),
        .fwdB   (fwdB),
        .wbData (wbData),
        .exMem  (exMem)
    );

    memoryStage uMemory (
        .clk        (clk),
        .reset      (reset),
        .exMem      (exMem),
        .memWb      (memWb),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .storeEvent (storeEvent),
        .fin        (fin)
    );

    hazardUnit uHazard (
        .ifId     (ifId),
        .idEx     (idEx),
        .exMem    (exMem),
        .memWb    (memWb),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

endmodule

// ==== logic/mipsPkg.sv ====
`include "mips_macros.svh"

package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        rType = 6'd0,
        j     = 6'd2,
        beq   = 6'd4,
        addi  = 6'd8,
        lw    = 6'd35,
        sw    = 6'd43,
        halt  = 6'd63
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // source of an execute operand
    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb
    } fwdSelT;

    // decode controls, all zero for a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;
        logic  regDst;
        logic  branch;
        logic  jump;
        logic  halt;
        logic  useFunct;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_WORD-1:0] instr;
        logic [`MIPS_WORD-1:0] pcNext;
    } ifIdT;

    typedef struct packed {
        ctrlT                      ctrl;
        logic [`MIPS_WORD-1:0]     rsVal;
        logic [`MIPS_WORD-1:0]     rtVal;
        logic [`MIPS_WORD-1:0]     imm;
        logic [`MIPS_REG_ADDR-1:0] rs;
        logic [`MIPS_REG_ADDR-1:0] rt;
        logic [`MIPS_REG_ADDR-1:0] rd;
        logic [5:0]                funct;
        logic [`MIPS_WORD-1:0]     branchTarget;
        logic [`MIPS_WORD-1:0]     jumpTarget;
    } idExT;

    typedef struct packed {
        logic                      regWrite;
        logic                      memRead;
        logic                      memWrite;
        logic                      memToReg;
        logic                      branch;
        logic                      jump;
        logic                      halt;
        logic [`MIPS_WORD-1:0]     aluResult;
        logic                      zero;
        logic [`MIPS_WORD-1:0]     storeData;
        logic [`MIPS_REG_ADDR-1:0] dest;
        logic [`MIPS_WORD-1:0]     branchTarget;
        logic [`MIPS_WORD-1:0]     jumpTarget;
    } exMemT;

    typedef struct packed {
        logic                      regWrite;
        logic                      memToReg;
        logic                      halt;
        logic [`MIPS_WORD-1:0]     aluResult;
        logic [`MIPS_WORD-1:0]     loadData;
        logic [`MIPS_REG_ADDR-1:0] dest;
    } memWbT;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_WORD-1:0] addr;
        logic [`MIPS_WORD-1:0] data;
    } storeEventT;

endpackage

// ==== logic/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data path and byte address width
`define MIPS_WORD 32

// register index width, 32 architectural registers
`define MIPS_REG_ADDR 5

// memory sizes in words
// both memories are indexed by byte address bits 9:2
`define MIPS_IMEM_DEPTH 256
`define MIPS_DMEM_DEPTH 256

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif
